// File: source/axil_defs.svh
// AXI4-Lite split subsystem widths, outstanding limit and target sizing
`ifndef AXIL_DEFS_SVH
`define AXIL_DEFS_SVH

// ------------------------------------------------
// Bus widths
// ------------------------------------------------
`define AXIL_ADDR_W 16
`define AXIL_DATA_W 32
`define AXIL_STRB_W 4

// Requests in flight per direction, counted at the split
`define AXIL_MAX_OUTSTANDING 4

// ------------------------------------------------
// Memory targets
// ------------------------------------------------
// Depth in 32-bit words
`define TRUNK_WORDS  256
`define BRANCH_WORDS 16

// Cycles from accept to response valid
`define TRUNK_DELAY  1
`define BRANCH_DELAY 5

`endif

// File: source/axil_pkg.sv
// AXI4-Lite protocol types shared by the split and its targets
`default_nettype none
`include "axil_defs.svh"

package axil_pkg;

  // Response codes as carried on BRESP and RRESP
  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    EXOKAY = 2'b01,
    SLVERR = 2'b10,
    DECERR = 2'b11
  } axil_resp_e;

  // Protection field
  // bit 0 privileged, bit 1 non-secure, bit 2 instruction
  typedef logic [2:0] axil_prot_t;

endpackage

`default_nettype wire

// File: source/split_pkg.sv
// Split subsystem types for request routing and target sequencing
`default_nettype none
`include "axil_defs.svh"

package split_pkg;

  // Destination of a request after address decode
  typedef enum logic {
    ROUTE_TRUNK  = 1'b0,
    ROUTE_BRANCH = 1'b1
  } route_e;

  // Memory target FSM
  typedef enum logic [1:0] {
    TGT_IDLE,
    TGT_WAIT,
    TGT_RESP
  } tgt_state_e;

endpackage

`default_nettype wire

// File: source/axil_flow_reg.sv
// Two-entry valid/ready slice with push_ready and pop_valid taken from registers
`timescale 1ns/10ps
`default_nettype none
`include "axil_defs.svh"

module axil_flow_reg #(
  parameter int WIDTH = 8
) (
  input  wire              clk,
  input  wire              rst,
  input  wire              push_valid,
  output logic             push_ready,
  input  wire  [WIDTH-1:0] push_data,
  output logic             pop_valid,
  input  wire              pop_ready,
  output logic [WIDTH-1:0] pop_data
);

  logic [WIDTH-1:0] entry [2];
  logic             wr_ptr;
  logic             rd_ptr;
  logic [1:0]       count;
  logic             push_fire;
  logic             pop_fire;

  // With two entries a push and a pop can both happen every cycle
  assign push_ready = (count != 2'd2);
  assign pop_valid  = (count != 2'd0);
  assign pop_data   = entry[rd_ptr];

  assign push_fire = push_valid && push_ready;
  assign pop_fire  = pop_valid && pop_ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= 1'b0;
      rd_ptr <= 1'b0;
      count  <= 2'd0;
    end else begin
      if (push_fire) wr_ptr <= !wr_ptr;
      if (pop_fire) rd_ptr <= !rd_ptr;
      count <= count + {1'b0, push_fire} - {1'b0, pop_fire};
    end
  end

  always_ff @(posedge clk) begin
    if (push_fire) entry[wr_ptr] <= push_data;
  end

  // Head entry must not move while the consumer stalls
  pop_data_held_a: assert property (@(posedge clk) disable iff (rst)
    pop_valid && !pop_ready |=> pop_valid && $stable(pop_data));

endmodule

`default_nettype wire

// File: source/axil_route_tracker.sv
// Outstanding request counter that holds back a route switch until the count drains
`timescale 1ns/10ps
`default_nettype none
`include "axil_defs.svh"

module axil_route_tracker
  import split_pkg::*;
(
  input  wire    clk,
  input  wire    rst,
  input  route_e req_route,
  input  wire    issue,
  input  wire    retire,
  output logic   allow
);

  localparam int CNT_W = $clog2(`AXIL_MAX_OUTSTANDING + 1);
  localparam logic [CNT_W-1:0] CNT_MAX = CNT_W'(`AXIL_MAX_OUTSTANDING);

  logic [CNT_W-1:0] count;
  route_e           last_route;

  always_ff @(posedge clk) begin
    if (rst) begin
      count      <= '0;
      last_route <= ROUTE_TRUNK;
    end else begin
      // Saturate at both ends
      if (issue && !retire && count != CNT_MAX) count <= count + 1'b1;
      else if (retire && !issue && count != '0) count <= count - 1'b1;
      if (issue) last_route <= req_route;
    end
  end

  // Same destination keeps the response order, so only a switch has to wait
  assign allow = (count == '0) || ((count < CNT_MAX) && (req_route == last_route));

  no_retire_when_empty_a: assert property (@(posedge clk) disable iff (rst)
    retire |-> count != '0);
  no_issue_when_full_a: assert property (@(posedge clk) disable iff (rst)
    issue |-> count != CNT_MAX);

endmodule

`default_nettype wire

// File: source/axil_split.sv
// AXI4-Lite 1:2 split routing by an inclusive address window to branch, else trunk
`timescale 1ns/10ps
`default_nettype none
`include "axil_defs.svh"

module axil_split
  import axil_pkg::*;
  import split_pkg::*;
(
  input  wire                      clk,
  input  wire                      rst,
  input  wire  [`AXIL_ADDR_W-1:0]  branch_start_addr,
  input  wire  [`AXIL_ADDR_W-1:0]  branch_end_addr,
  // Root, from the initiator
  input  wire  [`AXIL_ADDR_W-1:0]  root_awaddr,
  input  axil_prot_t               root_awprot,
  input  wire                      root_awvalid,
  output logic                     root_awready,
  input  wire  [`AXIL_DATA_W-1:0]  root_wdata,
  input  wire  [`AXIL_STRB_W-1:0]  root_wstrb,
  input  wire                      root_wvalid,
  output logic                     root_wready,
  output axil_resp_e               root_bresp,
  output logic                     root_bvalid,
  input  wire                      root_bready,
  input  wire  [`AXIL_ADDR_W-1:0]  root_araddr,
  input  axil_prot_t               root_arprot,
  input  wire                      root_arvalid,
  output logic                     root_arready,
  output logic [`AXIL_DATA_W-1:0]  root_rdata,
  output axil_resp_e               root_rresp,
  output logic                     root_rvalid,
  input  wire                      root_rready,
  // Trunk, to the default target
  output logic [`AXIL_ADDR_W-1:0]  trunk_awaddr,
  output axil_prot_t               trunk_awprot,
  output logic                     trunk_awvalid,
  input  wire                      trunk_awready,
  output logic [`AXIL_DATA_W-1:0]  trunk_wdata,
  output logic [`AXIL_STRB_W-1:0]  trunk_wstrb,
  output logic                     trunk_wvalid,
  input  wire                      trunk_wready,
  input  axil_resp_e               trunk_bresp,
  input  wire                      trunk_bvalid,
  output logic                     trunk_bready,
  output logic [`AXIL_ADDR_W-1:0]  trunk_araddr,
  output axil_prot_t               trunk_arprot,
  output logic                     trunk_arvalid,
  input  wire                      trunk_arready,
  input  wire  [`AXIL_DATA_W-1:0]  trunk_rdata,
  input  axil_resp_e               trunk_rresp,
  input  wire                      trunk_rvalid,
  output logic                     trunk_rready,
  // Branch, to the windowed target
  output logic [`AXIL_ADDR_W-1:0]  branch_awaddr,
  output axil_prot_t               branch_awprot,
  output logic                     branch_awvalid,
  input  wire                      branch_awready,
  output logic [`AXIL_DATA_W-1:0]  branch_wdata,
  output logic [`AXIL_STRB_W-1:0]  branch_wstrb,
  output logic                     branch_wvalid,
  input  wire                      branch_wready,
  input  axil_resp_e               branch_bresp,
  input  wire                      branch_bvalid,
  output logic                     branch_bready,
  output logic [`AXIL_ADDR_W-1:0]  branch_araddr,
  output axil_prot_t               branch_arprot,
  output logic                     branch_arvalid,
  input  wire                      branch_arready,
  input  wire  [`AXIL_DATA_W-1:0]  branch_rdata,
  input  axil_resp_e               branch_rresp,
  input  wire                      branch_rvalid,
  output logic                     branch_rready
);

  localparam int AW_W = `AXIL_ADDR_W + $bits(axil_prot_t) + 1;
  localparam int W_W  = `AXIL_DATA_W + `AXIL_STRB_W + 1;

  route_e                  ar_route, aw_route;
  logic                    rd_allow, wr_allow, wr_accept;
  logic                    aw_push_ready, aw_pop_valid, aw_pop_ready;
  logic                    w_push_ready, w_pop_valid, w_pop_ready;
  logic [AW_W-1:0]         aw_pop_data;
  logic [W_W-1:0]          w_pop_data;
  logic [`AXIL_ADDR_W-1:0] aw_q_addr;
  axil_prot_t              aw_q_prot;
  logic                    aw_q_tag;
  logic [`AXIL_DATA_W-1:0] w_q_data;
  logic [`AXIL_STRB_W-1:0] w_q_strb;
  logic                    w_q_tag;

  // ------------------------------------------------
  // Address decode, window bounds inclusive
  // ------------------------------------------------
  assign ar_route = (root_araddr >= branch_start_addr && root_araddr <= branch_end_addr) ?
                    ROUTE_BRANCH : ROUTE_TRUNK;
  assign aw_route = (root_awaddr >= branch_start_addr && root_awaddr <= branch_end_addr) ?
                    ROUTE_BRANCH : ROUTE_TRUNK;

  // ------------------------------------------------
  // Read path, combinational
  // ------------------------------------------------
  axil_route_tracker rd_tracker (
    .clk       (clk),
    .rst       (rst),
    .req_route (ar_route),
    .issue     (root_arvalid && root_arready),
    .retire    (root_rvalid && root_rready),
    .allow     (rd_allow)
  );

  assign trunk_arvalid  = root_arvalid && rd_allow && (ar_route == ROUTE_TRUNK);
  assign branch_arvalid = root_arvalid && rd_allow && (ar_route == ROUTE_BRANCH);
  assign root_arready   = (trunk_arvalid && trunk_arready) || (branch_arvalid && branch_arready);
  assign trunk_araddr   = root_araddr;
  assign branch_araddr  = root_araddr;
  assign trunk_arprot   = root_arprot;
  assign branch_arprot  = root_arprot;

  // ------------------------------------------------
  // Write path through the slices
  // ------------------------------------------------
  axil_route_tracker wr_tracker (
    .clk       (clk),
    .rst       (rst),
    .req_route (aw_route),
    .issue     (wr_accept),
    .retire    (root_bvalid && root_bready),
    .allow     (wr_allow)
  );

  // AW and W enter together so both slices carry the same route tag
  assign wr_accept = root_awvalid && root_wvalid && aw_push_ready && w_push_ready && wr_allow;
  assign root_awready = wr_accept;
  assign root_wready  = wr_accept;

  axil_flow_reg #(.WIDTH(AW_W)) aw_slice (
    .clk        (clk),
    .rst        (rst),
    .push_valid (wr_accept),
    .push_ready (aw_push_ready),
    .push_data  ({root_awaddr, root_awprot, aw_route}),
    .pop_valid  (aw_pop_valid),
    .pop_ready  (aw_pop_ready),
    .pop_data   (aw_pop_data)
  );

  axil_flow_reg #(.WIDTH(W_W)) w_slice (
    .clk        (clk),
    .rst        (rst),
    .push_valid (wr_accept),
    .push_ready (w_push_ready),
    .push_data  ({root_wdata, root_wstrb, aw_route}),
    .pop_valid  (w_pop_valid),
    .pop_ready  (w_pop_ready),
    .pop_data   (w_pop_data)
  );

  assign {aw_q_addr, aw_q_prot, aw_q_tag} = aw_pop_data;
  assign {w_q_data, w_q_strb, w_q_tag} = w_pop_data;

  assign trunk_awvalid  = aw_pop_valid && (aw_q_tag == ROUTE_TRUNK);
  assign branch_awvalid = aw_pop_valid && (aw_q_tag == ROUTE_BRANCH);
  assign trunk_wvalid   = w_pop_valid && (w_q_tag == ROUTE_TRUNK);
  assign branch_wvalid  = w_pop_valid && (w_q_tag == ROUTE_BRANCH);
  assign aw_pop_ready   = (trunk_awvalid && trunk_awready) || (branch_awvalid && branch_awready);
  assign w_pop_ready    = (trunk_wvalid && trunk_wready) || (branch_wvalid && branch_wready);

  assign trunk_awaddr  = aw_q_addr;
  assign branch_awaddr = aw_q_addr;
  assign trunk_awprot  = aw_q_prot;
  assign branch_awprot = aw_q_prot;
  assign trunk_wdata   = w_q_data;
  assign branch_wdata  = w_q_data;
  assign trunk_wstrb   = w_q_strb;
  assign branch_wstrb  = w_q_strb;

  // ------------------------------------------------
  // Response merge
  // ------------------------------------------------
  // Ordering by the trackers keeps at most one side valid
  assign root_rvalid   = trunk_rvalid || branch_rvalid;
  assign root_rdata    = branch_rvalid ? branch_rdata : trunk_rdata;
  assign root_rresp    = branch_rvalid ? branch_rresp : trunk_rresp;
  assign trunk_rready  = root_rready;
  assign branch_rready = root_rready;

  assign root_bvalid   = trunk_bvalid || branch_bvalid;
  assign root_bresp    = branch_bvalid ? branch_bresp : trunk_bresp;
  assign trunk_bready  = root_bready;
  assign branch_bready = root_bready;

  window_ordered_a: assert property (@(posedge clk) disable iff (rst)
    branch_end_addr > branch_start_addr);
  rvalid_onehot_a: assert property (@(posedge clk) disable iff (rst)
    !(trunk_rvalid && branch_rvalid));
  bvalid_onehot_a: assert property (@(posedge clk) disable iff (rst)
    !(trunk_bvalid && branch_bvalid));

endmodule

`default_nettype wire

// File: source/axil_mem_target.sv
// AXI4-Lite word memory target with fixed response latency and optional secure-only access
`timescale 1ns/10ps
`default_nettype none
`include "axil_defs.svh"

module axil_mem_target
  import axil_pkg::*;
  import split_pkg::*;
#(
  parameter int WORDS       = 256,
  parameter int RESP_DELAY  = 1,
  parameter bit SECURE_ONLY = 1'b0
) (
  input  wire                      clk,
  input  wire                      rst,
  input  wire  [`AXIL_ADDR_W-1:0]  awaddr,
  input  axil_prot_t               awprot,
  input  wire                      awvalid,
  output logic                     awready,
  input  wire  [`AXIL_DATA_W-1:0]  wdata,
  input  wire  [`AXIL_STRB_W-1:0]  wstrb,
  input  wire                      wvalid,
  output logic                     wready,
  output axil_resp_e               bresp,
  output logic                     bvalid,
  input  wire                      bready,
  input  wire  [`AXIL_ADDR_W-1:0]  araddr,
  input  axil_prot_t               arprot,
  input  wire                      arvalid,
  output logic                     arready,
  output logic [`AXIL_DATA_W-1:0]  rdata,
  output axil_resp_e               rresp,
  output logic                     rvalid,
  input  wire                      rready
);

  localparam int IDX_W = $clog2(WORDS);
  localparam int CNT_W = $clog2(RESP_DELAY + 1);

  logic [`AXIL_DATA_W-1:0] mem [WORDS];
  tgt_state_e              state;
  logic [CNT_W-1:0]        delay_cnt;
  logic                    resp_is_write;
  axil_resp_e              resp_q;
  logic [`AXIL_DATA_W-1:0] rdata_q;
  logic                    wr_acc, rd_acc, wr_reject, rd_reject;
  logic [IDX_W-1:0]        wr_idx, rd_idx;

  // A write with both AW and W present wins over a read
  assign awready = (state == TGT_IDLE) && awvalid && wvalid;
  assign wready  = awready;
  assign arready = (state == TGT_IDLE) && !(awvalid && wvalid);
  assign wr_acc  = awvalid && awready;
  assign rd_acc  = arvalid && arready;

  // prot[1] marks a non-secure access
  assign wr_reject = SECURE_ONLY && awprot[1];
  assign rd_reject = SECURE_ONLY && arprot[1];
  assign wr_idx    = awaddr[IDX_W+1:2];
  assign rd_idx    = araddr[IDX_W+1:2];

  assign bvalid = (state == TGT_RESP) && resp_is_write;
  assign rvalid = (state == TGT_RESP) && !resp_is_write;
  assign bresp  = resp_q;
  assign rresp  = resp_q;
  assign rdata  = rdata_q;

  // ------------------------------------------------
  // FSM and latency counter
  // ------------------------------------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      state         <= TGT_IDLE;
      delay_cnt     <= '0;
      resp_is_write <= 1'b0;
    end else begin
      case (state)
        TGT_IDLE: begin
          if (wr_acc || rd_acc) begin
            resp_is_write <= wr_acc;
            delay_cnt     <= CNT_W'(RESP_DELAY - 1);
            state         <= (RESP_DELAY == 1) ? TGT_RESP : TGT_WAIT;
          end
        end
        TGT_WAIT: begin
          delay_cnt <= delay_cnt - 1'b1;
          if (delay_cnt == CNT_W'(1)) state <= TGT_RESP;
        end
        TGT_RESP: begin
          if ((bvalid && bready) || (rvalid && rready)) state <= TGT_IDLE;
        end
        default: state <= TGT_IDLE;
      endcase
    end
  end

  // Storage and response payload, captured at accept
  always_ff @(posedge clk) begin
    if (wr_acc) begin
      resp_q <= wr_reject ? SLVERR : OKAY;
      for (int b = 0; b < `AXIL_STRB_W; b++) begin
        if (wstrb[b] && !wr_reject) mem[wr_idx][8*b +: 8] <= wdata[8*b +: 8];
      end
    end else if (rd_acc) begin
      resp_q  <= rd_reject ? SLVERR : OKAY;
      rdata_q <= rd_reject ? '0 : mem[rd_idx];
    end
  end

  bvalid_held_a: assert property (@(posedge clk) disable iff (rst)
    bvalid && !bready |=> bvalid);
  rvalid_held_a: assert property (@(posedge clk) disable iff (rst)
    rvalid && !rready |=> rvalid);

endmodule

`default_nettype wire

// File: source/axil_split_top.sv
// Split subsystem top joining the 1:2 split to a trunk memory and a secure branch store
`timescale 1ns/10ps
`default_nettype none
`include "axil_defs.svh"

module axil_split_top
  import axil_pkg::*;
(
  input  wire                      clk,
  input  wire                      rst,
  input  wire  [`AXIL_ADDR_W-1:0]  branch_start_addr,
  input  wire  [`AXIL_ADDR_W-1:0]  branch_end_addr,
  input  wire  [`AXIL_ADDR_W-1:0]  root_awaddr,
  input  axil_prot_t               root_awprot,
  input  wire                      root_awvalid,
  output logic                     root_awready,
  input  wire  [`AXIL_DATA_W-1:0]  root_wdata,
  input  wire  [`AXIL_STRB_W-1:0]  root_wstrb,
  input  wire                      root_wvalid,
  output logic                     root_wready,
  output axil_resp_e               root_bresp,
  output logic                     root_bvalid,
  input  wire                      root_bready,
  input  wire  [`AXIL_ADDR_W-1:0]  root_araddr,
  input  axil_prot_t               root_arprot,
  input  wire                      root_arvalid,
  output logic                     root_arready,
  output logic [`AXIL_DATA_W-1:0]  root_rdata,
  output axil_resp_e               root_rresp,
  output logic                     root_rvalid,
  input  wire                      root_rready
);

  logic [`AXIL_ADDR_W-1:0] trunk_awaddr, trunk_araddr, branch_awaddr, branch_araddr;
  axil_prot_t              trunk_awprot, trunk_arprot, branch_awprot, branch_arprot;
  logic [`AXIL_DATA_W-1:0] trunk_wdata, trunk_rdata, branch_wdata, branch_rdata;
  logic [`AXIL_STRB_W-1:0] trunk_wstrb, branch_wstrb;
  axil_resp_e              trunk_bresp, trunk_rresp, branch_bresp, branch_rresp;
  logic trunk_awvalid, trunk_awready, trunk_wvalid, trunk_wready, trunk_bvalid;
  logic trunk_bready, trunk_arvalid, trunk_arready, trunk_rvalid, trunk_rready;
  logic branch_awvalid, branch_awready, branch_wvalid, branch_wready, branch_bvalid;
  logic branch_bready, branch_arvalid, branch_arready, branch_rvalid, branch_rready;

  axil_split split (.*);

  // Plain memory behind everything outside the window
  axil_mem_target #(
    .WORDS       (`TRUNK_WORDS),
    .RESP_DELAY  (`TRUNK_DELAY),
    .SECURE_ONLY (1'b0)
  ) trunk_mem (
    .clk (clk), .rst (rst),
    .awaddr (trunk_awaddr), .awprot (trunk_awprot),
    .awvalid (trunk_awvalid), .awready (trunk_awready),
    .wdata (trunk_wdata), .wstrb (trunk_wstrb), .wvalid (trunk_wvalid), .wready (trunk_wready),
    .bresp (trunk_bresp), .bvalid (trunk_bvalid), .bready (trunk_bready),
    .araddr (trunk_araddr), .arprot (trunk_arprot),
    .arvalid (trunk_arvalid), .arready (trunk_arready),
    .rdata (trunk_rdata), .rresp (trunk_rresp), .rvalid (trunk_rvalid), .rready (trunk_rready)
  );

  // Secure configuration store inside the window
  axil_mem_target #(
    .WORDS       (`BRANCH_WORDS),
    .RESP_DELAY  (`BRANCH_DELAY),
    .SECURE_ONLY (1'b1)
  ) branch_mem (
    .clk (clk), .rst (rst),
    .awaddr (branch_awaddr), .awprot (branch_awprot),
    .awvalid (branch_awvalid), .awready (branch_awready),
    .wdata (branch_wdata), .wstrb (branch_wstrb),
    .wvalid (branch_wvalid), .wready (branch_wready),
    .bresp (branch_bresp), .bvalid (branch_bvalid), .bready (branch_bready),
    .araddr (branch_araddr), .arprot (branch_arprot),
    .arvalid (branch_arvalid), .arready (branch_arready),
    .rdata (branch_rdata), .rresp (branch_rresp),
    .rvalid (branch_rvalid), .rready (branch_rready)
  );

endmodule

`default_nettype wire

// File: verif/tb_clock_gen.sv
// Testbench clock source, free running with a 4 ns period
`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen #(
  parameter int HALF_NS = 2
) (
  output logic clk
);

  initial begin
    clk = 1'b0;
    forever #(HALF_NS) clk = ~clk;
  end

endmodule

`default_nettype wire

// File: verif/axil_split_tb.sv
// Directed testbench for the AXI4-Lite split subsystem against a shadow memory model
`timescale 1ns/10ps
`default_nettype none
`include "axil_defs.svh"

module axil_split_tb
  import axil_pkg::*;
();

  localparam int TIMEOUT = 200;
  localparam logic [15:0] WIN_START = 16'h8000;
  localparam logic [15:0] WIN_END   = 16'h803F;

  logic clk;
  logic rst;
  logic [`AXIL_ADDR_W-1:0] branch_start_addr, branch_end_addr;
  logic [`AXIL_ADDR_W-1:0] root_awaddr, root_araddr;
  axil_prot_t              root_awprot, root_arprot;
  logic [`AXIL_DATA_W-1:0] root_wdata, root_rdata;
  logic [`AXIL_STRB_W-1:0] root_wstrb;
  axil_resp_e              root_bresp, root_rresp;
  logic root_awvalid, root_awready, root_wvalid, root_wready, root_bvalid, root_bready;
  logic root_arvalid, root_arready, root_rvalid, root_rready;

  logic [31:0] rng_state;
  logic [31:0] trunk_shadow [`TRUNK_WORDS];
  logic [31:0] branch_shadow [`BRANCH_WORDS];
  int test_errors, error_count, tests_passed, tests_failed;

  // Pending requests of the next burst, and expected responses in issue order
  logic [15:0] req_addr_q [$];
  axil_prot_t  req_prot_q [$];
  logic [31:0] req_data_q [$];
  logic [3:0]  req_strb_q [$];
  logic [31:0] exp_data_q [$];
  logic [1:0]  exp_resp_q [$];

  tb_clock_gen clock_gen (.clk(clk));

  axil_split_top uut (.*);

  // --------------------------------------------------
  // Helpers and reference model
  // --------------------------------------------------
  function automatic logic [31:0] next_rand();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  function automatic bit in_window(input logic [15:0] addr);
    return (addr >= WIN_START) && (addr <= WIN_END);
  endfunction

  function automatic logic [31:0] merge_strb(input logic [31:0] old, input logic [31:0] data,
                                             input logic [3:0] strb);
    logic [31:0] res;
    res = old;
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) res[8*b +: 8] = data[8*b +: 8];
    end
    return res;
  endfunction

  // Even requests go to trunk words 0x40..0x4F, odd ones to the branch store
  function automatic logic [15:0] pick_addr(input int k, input logic [31:0] r);
    return {(k % 2 == 0) ? 8'h01 : 8'h80, 2'b00, r[3:0], 2'b00};
  endfunction

  task automatic model_read(input logic [15:0] addr, input axil_prot_t prot,
                            output logic [31:0] data, output logic [1:0] resp);
    if (!in_window(addr)) begin
      data = trunk_shadow[addr[9:2]];
      resp = OKAY;
    end else if (prot[1]) begin
      data = 32'h0;
      resp = SLVERR;
    end else begin
      data = branch_shadow[addr[5:2]];
      resp = OKAY;
    end
  endtask

  task automatic model_write(input logic [15:0] addr, input axil_prot_t prot,
                             input logic [31:0] data, input logic [3:0] strb,
                             output logic [1:0] resp);
    resp = OKAY;
    if (!in_window(addr)) begin
      trunk_shadow[addr[9:2]] = merge_strb(trunk_shadow[addr[9:2]], data, strb);
    end else if (prot[1]) begin
      resp = SLVERR;
    end else begin
      branch_shadow[addr[5:2]] = merge_strb(branch_shadow[addr[5:2]], data, strb);
    end
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("Error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
      test_errors++;
    end
  endtask

  task automatic abort_run(input string why);
    $display("Run aborted at %0t ns: %s", $time, why);
    $display("TESTBENCH FAILED");
    $finish;
  endtask

  // One more cycle of a bounded wait, ending at the falling edge
  task automatic tick_wait(inout int waited, input string what);
    waited = waited + 1;
    if (waited > TIMEOUT) abort_run(what);
    @(negedge clk);
  endtask

  task automatic finish_test(input string name);
    if (test_errors == 0) begin
      tests_passed++;
      $display("Test %s passed", name);
    end else begin
      tests_failed++;
      $display("Test %s failed with %0d errors", name, test_errors);
    end
    error_count += test_errors;
    test_errors = 0;
  endtask

  // --------------------------------------------------
  // Burst engine
  // --------------------------------------------------
  task automatic queue_req(input logic [15:0] addr, input axil_prot_t prot,
                           input logic [31:0] data, input logic [3:0] strb);
    req_addr_q.push_back(addr);
    req_prot_q.push_back(prot);
    req_data_q.push_back(data);
    req_strb_q.push_back(strb);
  endtask

  task automatic queue_mixed(input int n);
    logic [31:0] r;
    int k;
    for (k = 0; k < n; k++) begin
      r = next_rand();
      queue_req(pick_addr(k, r), (r[9:8] == 2'b00) ? 3'b010 : 3'b000, next_rand(), r[7:4]);
    end
  endtask

  task automatic issue_requests(input bit is_write);
    logic [31:0] exp_data;
    logic [1:0] exp_resp;
    int waited;
    int k;
    for (k = 0; k < req_addr_q.size(); k++) begin
      if (is_write) begin
        root_awaddr  = req_addr_q[k];
        root_awprot  = req_prot_q[k];
        root_wdata   = req_data_q[k];
        root_wstrb   = req_strb_q[k];
        root_awvalid = 1'b1;
        root_wvalid  = 1'b1;
      end else begin
        root_araddr  = req_addr_q[k];
        root_arprot  = req_prot_q[k];
        root_arvalid = 1'b1;
      end
      waited = 0;
      @(negedge clk);
      while (!(is_write ? root_awready : root_arready))
        tick_wait(waited, "split never accepted a request");
      if (is_write) begin
        check_value("root_wready", root_wready, 1'b1);
        model_write(req_addr_q[k], req_prot_q[k], req_data_q[k], req_strb_q[k], exp_resp);
        exp_data = 32'h0;
      end else begin
        model_read(req_addr_q[k], req_prot_q[k], exp_data, exp_resp);
      end
      exp_data_q.push_back(exp_data);
      exp_resp_q.push_back(exp_resp);
      @(posedge clk);
      #1;
    end
    root_awvalid = 1'b0;
    root_wvalid  = 1'b0;
    root_arvalid = 1'b0;
  endtask

  task automatic collect_responses(input int n, input bit is_write, input bit stall);
    logic [31:0] data, held_data, exp_data;
    logic [1:0] resp, held_resp;
    logic vld, rdy;
    bit held;
    int got, waited, low_left;
    string v_name, d_name, r_name;
    if (is_write) begin
      v_name = "root_bvalid";
      r_name = "root_bresp";
    end else begin
      v_name = "root_rvalid";
      d_name = "root_rdata";
      r_name = "root_rresp";
    end
    got = 0;
    waited = 0;
    low_left = 0;
    held = 1'b0;
    while (got < n) begin
      // Ready drops for random stretches of one to six cycles
      if (stall && low_left == 0 && next_rand() % 3 == 0) low_left = 1 + next_rand() % 6;
      rdy = (low_left == 0);
      if (low_left > 0) low_left = low_left - 1;
      if (is_write) root_bready = rdy;
      else root_rready = rdy;
      @(negedge clk);
      vld  = is_write ? root_bvalid : root_rvalid;
      resp = is_write ? root_bresp : root_rresp;
      data = is_write ? 32'h0 : root_rdata;
      if (held) begin
        check_value(v_name, vld, 1'b1);
        if (!is_write) check_value(d_name, data, held_data);
        check_value(r_name, resp, held_resp);
      end
      if (vld && rdy) begin
        if (exp_resp_q.size() == 0) begin
          $display("Error at %0t ns: response arrived with no request outstanding", $time);
          test_errors++;
        end else begin
          exp_data = exp_data_q.pop_front();
          if (!is_write) check_value(d_name, data, exp_data);
          check_value(r_name, resp, exp_resp_q.pop_front());
        end
        got++;
        waited = 0;
        held = 1'b0;
      end else begin
        held = vld;
        held_data = data;
        held_resp = resp;
        waited++;
        if (waited > TIMEOUT) abort_run("a response never arrived");
      end
      @(posedge clk);
      #1;
    end
    root_bready = 1'b0;
    root_rready = 1'b0;
  endtask

  task automatic run_burst(input bit is_write, input bit stall);
    int n;
    n = req_addr_q.size();
    fork
      issue_requests(is_write);
      collect_responses(n, is_write, stall);
    join
    req_addr_q.delete();
    req_prot_q.delete();
    req_data_q.delete();
    req_strb_q.delete();
    // Nothing may linger once every response has been taken
    @(negedge clk);
    check_value("root_bvalid", root_bvalid, 1'b0);
    check_value("root_rvalid", root_rvalid, 1'b0);
    @(posedge clk);
    #1;
  endtask

  // --------------------------------------------------
  // Tests
  // --------------------------------------------------
  task automatic test_reset_state();
    @(negedge clk);
    check_value("root_bvalid", root_bvalid, 1'b0);
    check_value("root_rvalid", root_rvalid, 1'b0);
    check_value("root_awready", root_awready, 1'b0);
    check_value("root_wready", root_wready, 1'b0);
    check_value("root_arready", root_arready, 1'b0);
    @(posedge clk);
    #1;
    finish_test("reset_state");
  endtask

  task automatic test_trunk_round_trip();
    logic [31:0] r;
    int i;
    for (i = 0; i < 16; i++) queue_req(16'h0100 + 16'(4 * i), 3'b000, next_rand(), 4'hF);
    run_burst(1'b1, 1'b0);
    // Partial writes through aliases above bit 9
    for (int j = 0; j < 24; j++) begin
      r = next_rand();
      i = next_rand() % 16;
      queue_req({1'b0, r[14:10], 2'b01, 2'b00, i[3:0], 2'b00}, 3'b000, next_rand(), r[3:0]);
    end
    run_burst(1'b1, 1'b0);
    for (i = 0; i < 16; i++) queue_req(16'h0100 + 16'(4 * i), 3'b000, 32'h0, 4'h0);
    run_burst(1'b0, 1'b0);
    finish_test("trunk_round_trip");
  endtask

  task automatic test_window_bounds();
    int i;
    for (i = 0; i < 16; i++) queue_req(WIN_START + 16'(4 * i), 3'b000, next_rand(), 4'hF);
    run_burst(1'b1, 1'b0);
    queue_req(16'h7FFC, 3'b010, next_rand(), 4'hF);
    queue_req(16'h8040, 3'b010, next_rand(), 4'hF);
    queue_req(16'h8000, 3'b010, next_rand(), 4'hF);
    queue_req(16'h803C, 3'b010, next_rand(), 4'hF);
    run_burst(1'b1, 1'b0);
    queue_req(16'h7FFC, 3'b010, 32'h0, 4'h0);
    queue_req(16'h8040, 3'b010, 32'h0, 4'h0);
    queue_req(16'h8000, 3'b010, 32'h0, 4'h0);
    queue_req(16'h803C, 3'b010, 32'h0, 4'h0);
    queue_req(16'h8000, 3'b000, 32'h0, 4'h0);
    queue_req(16'h803C, 3'b000, 32'h0, 4'h0);
    run_burst(1'b0, 1'b0);
    finish_test("window_bounds");
  endtask

  task automatic test_rejection();
    queue_req(16'h8014, 3'b000, 32'hA5C3_0F17, 4'hF);
    queue_req(16'h8014, 3'b010, 32'h5A3C_F0E8, 4'hF);
    run_burst(1'b1, 1'b0);
    queue_req(16'h8014, 3'b000, 32'h0, 4'h0);
    queue_req(16'h8014, 3'b010, 32'h0, 4'h0);
    run_burst(1'b0, 1'b0);
    finish_test("rejection");
  endtask

  task automatic test_mixed_traffic(input string name, input bit stall, input int n);
    queue_mixed(n);
    run_burst(1'b0, stall);
    queue_mixed(n);
    run_burst(1'b1, stall);
    queue_mixed(n);
    run_burst(1'b0, stall);
    finish_test(name);
  endtask

  initial begin
    rng_state         = 32'd60826;
    test_errors       = 0;
    error_count       = 0;
    tests_passed      = 0;
    tests_failed      = 0;
    branch_start_addr = WIN_START;
    branch_end_addr   = WIN_END;
    root_awaddr  = '0;
    root_awprot  = '0;
    root_awvalid = 1'b0;
    root_wdata   = '0;
    root_wstrb   = '0;
    root_wvalid  = 1'b0;
    root_bready  = 1'b0;
    root_araddr  = '0;
    root_arprot  = '0;
    root_arvalid = 1'b0;
    root_rready  = 1'b0;
    rst = 1'b1;
    repeat (10) @(posedge clk);
    #1;
    rst = 1'b0;

    test_reset_state();
    test_trunk_round_trip();
    test_window_bounds();
    test_rejection();
    test_mixed_traffic("ordering", 1'b0, 12);
    test_mixed_traffic("back_pressure", 1'b1, 16);

    $display("Tests passed %0d, failed %0d, errors %0d", tests_passed, tests_failed,
             error_count);
    if (error_count == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: sim.f
+incdir+source
source/axil_pkg.sv
source/split_pkg.sv
source/axil_flow_reg.sv
source/axil_route_tracker.sv
source/axil_split.sv
source/axil_mem_target.sv
source/axil_split_top.sv
verif/tb_clock_gen.sv
verif/axil_split_tb.sv
